// ==== Bender.yml ====
package:
  name: packet_router

sources:
  # packages first, then the design from the leaves up
  - files:
      - hdl/router_pkg.sv
      - hdl/router_state_pkg.sv
      - hdl/packet_fifo.sv
      - hdl/input_sm.sv
      - hdl/output_sm.sv
      - hdl/packet_router.sv

  - target: test
    files:
      - testbench/packet_router_checker.sv
      - testbench/packet_router_tb.sv

// ==== hdl/input_sm.sv ====
`timescale 1ns/1ps
`default_nettype none

module input_sm (
    input  logic                                                 clk,
    input  logic                                                 reset_b,
    input  logic                                                 in_valid,
    input  router_pkg::router_word_t                             in_word,
    output logic                                                 suspend,
    output logic [router_pkg::num_ports-1:0]                     write,
    output router_pkg::router_word_t                             write_word,
    input  router_pkg::word_count_t [router_pkg::num_ports-1:0]  free_words
);

    router_state_pkg::input_state_t state;
    router_state_pkg::input_state_t next_state;
    router_pkg::port_addr_t         dest;          // held for the body of the packet
    router_pkg::port_addr_t         header_addr;
    logic                           addr_ok;
    logic                           room;
    logic                           header_stall;
    logic                           accept;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // header decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign header_addr = in_word.data[1:0];
    assign addr_ok     = (header_addr < router_pkg::num_ports);

    always_comb begin
        room = 1'b0;
        if (addr_ok) begin
            room = (free_words[header_addr] >= router_pkg::max_packet_words);
        end
    end

    // a header waits until its FIFO can take a packet of the longest length
    assign header_stall = in_valid & addr_ok & ~room;
    assign suspend      = (state == router_state_pkg::in_idle) & header_stall;
    assign accept       = in_valid & ~suspend;

    assign write_word = in_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // steering FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state = state;
        write      = '0;
        case (state)
            router_state_pkg::in_idle: begin
                if (in_valid && !header_stall) begin
                    if (addr_ok) begin
                        write[header_addr] = 1'b1;
                        next_state         = router_state_pkg::in_forward;
                    end else begin
                        next_state = router_state_pkg::in_drop;
                    end
                    if (in_word.eop) begin
                        next_state = router_state_pkg::in_idle;    // single word packet
                    end
                end
            end
            router_state_pkg::in_forward: begin
                if (in_valid) begin
                    write[dest] = 1'b1;        // room was reserved at the header
                    if (in_word.eop) begin
                        next_state = router_state_pkg::in_idle;
                    end
                end
            end
            router_state_pkg::in_drop: begin
                if (in_valid && in_word.eop) begin
                    next_state = router_state_pkg::in_idle;
                end
            end
            default: begin
                next_state = router_state_pkg::in_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= router_state_pkg::in_idle;
            dest  <= '0;
        end else begin
            state <= next_state;
            if (state == router_state_pkg::in_idle && accept && addr_ok) begin
                dest <= header_addr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/output_sm.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_sm (
    input  logic                      clk,
    input  logic                      reset_b,
    input  logic                      packet_empty,
    output logic                      pop,
    input  router_pkg::router_word_t  head,
    output logic                      ready,
    input  logic                      read,
    output router_pkg::out_beat_t     beat
);

    router_state_pkg::output_state_t state;
    router_state_pkg::output_state_t next_state;
    router_pkg::router_word_t        beat_word;    // last word taken from the FIFO
    logic                            beat_valid;
    logic                            hold_off_ready;

    // ready stays up through the eop beat and drops for the gap
    assign ready = (~packet_empty & ~hold_off_ready)
                 | (state == router_state_pkg::process_last);

    assign beat = '{valid: beat_valid, eop: beat_word.eop, data: beat_word.data};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drain FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state     = state;
        pop            = 1'b0;
        hold_off_ready = 1'b0;
        case (state)
            router_state_pkg::idle: begin
                if (read && !packet_empty) begin
                    pop        = 1'b1;             // header leaves the FIFO here
                    next_state = router_state_pkg::process_packet;
                end
            end
            router_state_pkg::process_packet: begin
                // the rest of a counted packet is always in the FIFO
                pop = 1'b1;
                if (head.eop) begin
                    next_state = router_state_pkg::process_last;
                end
            end
            router_state_pkg::process_last: begin
                hold_off_ready = 1'b1;
                next_state     = router_state_pkg::end_of_packet_1;
            end
            router_state_pkg::end_of_packet_1: begin
                hold_off_ready = 1'b1;
                next_state     = router_state_pkg::end_of_packet_2;
            end
            router_state_pkg::end_of_packet_2: begin
                hold_off_ready = 1'b1;
                next_state     = router_state_pkg::end_of_packet_3;
            end
            router_state_pkg::end_of_packet_3: begin
                hold_off_ready = 1'b1;
                next_state     = router_state_pkg::idle;
            end
            default: begin
                next_state = router_state_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state      <= router_state_pkg::idle;
            beat_valid <= 1'b0;
            beat_word  <= '0;
        end else begin
            state      <= next_state;
            beat_valid <= pop;                 // one beat per popped word
            if (pop) begin
                beat_word <= head;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/packet_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_fifo #(
    parameter int depth = router_pkg::fifo_depth
) (
    input  logic                        clk,
    input  logic                        reset_b,
    input  logic                        write,
    input  router_pkg::router_word_t    write_word,
    input  logic                        pop,
    output router_pkg::router_word_t    head,
    output logic                        packet_empty,
    output logic [$clog2(depth+1)-1:0]  free_words
);

    localparam int ptr_width = $clog2(depth);
    localparam int cnt_width = $clog2(depth + 1);

    router_pkg::router_word_t mem [depth];
    logic [ptr_width-1:0]     wr_ptr;
    logic [ptr_width-1:0]     rd_ptr;
    logic [cnt_width-1:0]     word_count;
    logic [cnt_width-1:0]     packet_count;
    logic                     packet_in;
    logic                     packet_out;

    // first word falls through to the head
    assign head = mem[rd_ptr];

    assign packet_in    = write & write_word.eop;  // a packet is complete once its eop lands
    assign packet_out   = pop & head.eop;
    assign packet_empty = (packet_count == '0);
    assign free_words   = cnt_width'(depth) - word_count;

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= write_word;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            word_count   <= '0;
            packet_count <= '0;
        end else begin
            if (write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            word_count   <= word_count + cnt_width'(write) - cnt_width'(pop);
            packet_count <= packet_count + cnt_width'(packet_in) - cnt_width'(packet_out);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/packet_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_router (
    input  logic                                               clk,
    input  logic                                               reset_b,
    input  logic                                               in_valid,
    input  router_pkg::router_word_t                           in_word,
    output logic                                               suspend,
    output logic [router_pkg::num_ports-1:0]                   ready,
    input  logic [router_pkg::num_ports-1:0]                   read,
    output router_pkg::out_beat_t [router_pkg::num_ports-1:0]  beat
);

    logic [router_pkg::num_ports-1:0]                     fifo_write;
    router_pkg::router_word_t                             fifo_word;
    router_pkg::word_count_t [router_pkg::num_ports-1:0]  free_words;
    router_pkg::router_word_t [router_pkg::num_ports-1:0] head;
    logic [router_pkg::num_ports-1:0]                     packet_empty;
    logic [router_pkg::num_ports-1:0]                     pop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    input_sm u_input_sm (
        .clk        (clk),
        .reset_b    (reset_b),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .suspend    (suspend),
        .write      (fifo_write),
        .write_word (fifo_word),
        .free_words (free_words)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one FIFO and drain FSM per port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < router_pkg::num_ports; i++) begin : g_port

        packet_fifo #(
            .depth (router_pkg::fifo_depth)
        ) u_packet_fifo (
            .clk          (clk),
            .reset_b      (reset_b),
            .write        (fifo_write[i]),
            .write_word   (fifo_word),
            .pop          (pop[i]),
            .head         (head[i]),
            .packet_empty (packet_empty[i]),
            .free_words   (free_words[i])
        );

        output_sm u_output_sm (
            .clk          (clk),
            .reset_b      (reset_b),
            .packet_empty (packet_empty[i]),
            .pop          (pop[i]),
            .head         (head[i]),
            .ready        (ready[i]),
            .read         (read[i]),
            .beat         (beat[i])
        );

    end

endmodule

`default_nettype wire

// ==== hdl/router_pkg.sv ====
`default_nettype none

package router_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int num_ports        = 3;     // output ports 0 to 2
    localparam int fifo_depth       = 32;    // must stay a power of two for pointer wrap
    localparam int max_packet_words = 16;    // header reserves this much room
    localparam int count_width      = $clog2(fifo_depth + 1);

    typedef logic [count_width-1:0] word_count_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // packet format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // address 3 selects no port and the packet is dropped
    typedef logic [1:0] port_addr_t;

    typedef struct packed {
        logic       eop;                     // last word of the packet
        logic [7:0] data;
    } router_word_t;

    typedef struct packed {
        logic       valid;                   // data and eop mean nothing while low
        logic       eop;
        logic [7:0] data;
    } out_beat_t;

endpackage

`default_nettype wire

// ==== hdl/router_state_pkg.sv ====
`default_nettype none

package router_state_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        in_idle,                             // waiting for a header
        in_forward,                          // copying a packet into its FIFO
        in_drop                              // swallowing a packet for address 3
    } input_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        idle            = 3'b000,
        process_packet  = 3'b001,
        process_last    = 3'b010,            // eop beat is on the port
        end_of_packet_1 = 3'b011,
        end_of_packet_2 = 3'b100,
        end_of_packet_3 = 3'b101
    } output_state_t;

endpackage

`default_nettype wire

// ==== packet_router.f ====
hdl/router_pkg.sv
hdl/router_state_pkg.sv
hdl/packet_fifo.sv
hdl/input_sm.sv
hdl/output_sm.sv
hdl/packet_router.sv
testbench/packet_router_checker.sv
testbench/packet_router_tb.sv

// ==== testbench/packet_router_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_router_checker (
    input logic                   clk,
    input logic                   reset_b,
    input logic                   write,
    input logic                   full,
    input logic                   pop,
    input logic                   packet_empty,
    input logic                   hold_off,      // one of the three end_of_packet states
    input router_pkg::out_beat_t  beat,
    input logic                   ready
);

    int fail_count = 0;                          // summed by the testbench at the end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FIFO and drain protocol
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!reset_b) write |-> !full
    ) else begin
        fail_count++;
        $error("FIFO written while full");
    end

    // every popped word belongs to a packet whose eop is already counted
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!reset_b) pop |-> !packet_empty
    ) else begin
        fail_count++;
        $error("pop with no complete packet in the FIFO");
    end

    a_quiet_hold_off: assert property (
        @(posedge clk) disable iff (!reset_b) hold_off |-> !beat.valid
    ) else begin
        fail_count++;
        $error("valid beat during the end of packet gap");
    end

    // the eop beat is shown in process_last, the gap follows it
    a_gap_after_eop: assert property (
        @(posedge clk) disable iff (!reset_b) (beat.valid && beat.eop) |=> !ready [*3]
    ) else begin
        fail_count++;
        $error("ready rose within three cycles of an eop beat");
    end

endmodule

`default_nettype wire

// ==== testbench/packet_router_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_router_tb;

    localparam int clk_period        = 40;
    localparam int total_packets     = 200;
    localparam int cycles_per_packet = 40;
    localparam int hold_cycles       = 400;      // outputs held this long to fill the FIFOs

    logic                                               clk = 1'b0;
    logic                                               reset_b;
    logic                                               in_valid;
    router_pkg::router_word_t                           in_word;
    logic                                               suspend;
    logic [router_pkg::num_ports-1:0]                   ready;
    logic [router_pkg::num_ports-1:0]                   read;
    router_pkg::out_beat_t [router_pkg::num_ports-1:0]  beat;

    int                       seed = 32'h8150;
    router_pkg::router_word_t exp_q [router_pkg::num_ports][$];   // words still owed per port
    int                       exp_count [router_pkg::num_ports] = '{default: 0};
    int                       rx_count [router_pkg::num_ports] = '{default: 0};
    bit                       collecting [router_pkg::num_ports];
    bit                       hold_read;
    int                       held_suspend_cycles = 0;
    int                       beat_errors = 0;
    int                       count_errors = 0;
    int                       protocol_errors = 0;

    always #(clk_period / 2) clk = ~clk;

    packet_router UUT (
        .clk      (clk),
        .reset_b  (reset_b),
        .in_valid (in_valid),
        .in_word  (in_word),
        .suspend  (suspend),
        .ready    (ready),
        .read     (read),
        .beat     (beat)
    );

    bind packet_fifo packet_router_checker u_fifo_checker (
        .clk (clk), .reset_b (reset_b), .write (write), .full (free_words == '0),
        .pop (pop), .packet_empty (packet_empty), .hold_off (1'b0),
        .beat ('0), .ready (1'b0)
    );

    bind output_sm packet_router_checker u_sm_checker (
        .clk (clk), .reset_b (reset_b), .write (1'b0), .full (1'b0),
        .pop (pop), .packet_empty (packet_empty),
        .hold_off (state inside {router_state_pkg::end_of_packet_1,
                                 router_state_pkg::end_of_packet_2,
                                 router_state_pkg::end_of_packet_3}),
        .beat (beat), .ready (ready)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compares and helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_beat(input int port, input router_pkg::out_beat_t got,
                              input router_pkg::out_beat_t exp);
        if (got !== exp) begin
            beat_errors++;
            $display("ERROR beat[%0d] got %h expected %h at %0t", port, got, exp, $time);
        end
    endtask

    task automatic check_count(input int port, input int got, input int exp);
        if (got != exp) begin
            count_errors++;
            $display("ERROR packet_count[%0d] got %h expected %h", port, got, exp);
        end
    endtask

    task automatic flag_protocol_error(input string msg);
        protocol_errors++;
        $display("%s at %0t", msg, $time);
    endtask

    function automatic int rand_between(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic int words_owed();
        int n = 0;
        foreach (exp_q[k]) n += exp_q[k].size();
        return n;
    endfunction

    function automatic int assertion_failures();
        return UUT.g_port[0].u_packet_fifo.u_fifo_checker.fail_count
             + UUT.g_port[1].u_packet_fifo.u_fifo_checker.fail_count
             + UUT.g_port[2].u_packet_fifo.u_fifo_checker.fail_count
             + UUT.g_port[0].u_output_sm.u_sm_checker.fail_count
             + UUT.g_port[1].u_output_sm.u_sm_checker.fail_count
             + UUT.g_port[2].u_output_sm.u_sm_checker.fail_count;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // packet source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // returns on the edge that accepts the word
    task automatic send_word(input router_pkg::router_word_t w);
        logic stalled;
        in_valid <= 1'b1;
        in_word  <= w;
        do begin
            @(negedge clk);
            stalled = suspend;
            @(posedge clk);
        end while (stalled);
    endtask

    task automatic send_packet(input int len, input int addr, input bit gaps);
        router_pkg::router_word_t w;
        router_pkg::router_word_t words [$];
        for (int i = 0; i < len; i++) begin
            if (gaps && i > 0 && rand_between(0, 5) == 0) begin
                in_valid <= 1'b0;
                repeat (rand_between(1, 3)) @(posedge clk);
            end
            w.eop  = (i == len - 1);
            w.data = 8'(rand_between(0, 255));
            if (i == 0) begin
                w.data[1:0] = 2'(addr);                // header carries the port
            end
            send_word(w);
            words.push_back(w);
        end
        if (addr < router_pkg::num_ports) begin
            foreach (words[j]) exp_q[addr].push_back(words[j]);
            exp_count[addr]++;
        end
    endtask

    task automatic send_random_packets(input int count);
        repeat (count) begin
            send_packet(rand_between(2, router_pkg::max_packet_words), rand_between(0, 3), 1'b1);
            if (rand_between(0, 3) == 0) begin
                in_valid <= 1'b0;
                repeat (rand_between(1, 4)) @(posedge clk);
            end
        end
        in_valid <= 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output consumers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic consume_port(input int k);
        router_pkg::router_word_t w;
        bit                       done;
        @(posedge reset_b);
        forever begin
            repeat ((rand_between(0, 3) == 0) ? rand_between(8, 24) : rand_between(0, 3))
                @(posedge clk);
            do begin
                @(negedge clk);
            end while (!ready[k] || hold_read);
            @(posedge clk);
            read[k]       <= 1'b1;
            collecting[k] = 1'b1;
            done          = 1'b0;
            while (!done) begin
                @(negedge clk);
                if (beat[k].valid && exp_q[k].size() == 0) begin
                    flag_protocol_error($sformatf("unexpected beat on port %0d", k));
                    done = 1'b1;
                end else if (beat[k].valid) begin
                    w = exp_q[k].pop_front();
                    check_beat(k, beat[k], '{valid: 1'b1, eop: w.eop, data: w.data});
                    done = w.eop;
                end
            end
            @(posedge clk);
            read[k]       <= 1'b0;
            collecting[k] = 1'b0;
            repeat (3) begin
                @(negedge clk);
                if (ready[k]) begin
                    flag_protocol_error($sformatf("ready high in the gap on port %0d", k));
                end
            end
        end
    endtask

    for (genvar k = 0; k < router_pkg::num_ports; k++) begin : g_port_tb
        initial consume_port(k);

        // an idle port with nothing owed shows no ready and no beat, in reset too
        always @(negedge clk) begin
            if (!collecting[k] && beat[k].valid) begin
                flag_protocol_error($sformatf("beat valid on port %0d with no read", k));
            end
            if (!collecting[k] && ready[k] && exp_count[k] == rx_count[k]) begin
                flag_protocol_error($sformatf("ready high on port %0d with no packet", k));
            end
            if (beat[k].valid && beat[k].eop) begin
                rx_count[k]++;                     // packets closed on the port
            end
        end
    end

    always @(negedge clk) begin
        if (suspend && hold_read) begin
            held_suspend_cycles++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence and watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        #(total_packets * cycles_per_packet * clk_period);
        $display("timeout after %0d cycles with packets still in flight",
                 total_packets * cycles_per_packet);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        reset_b   = 1'b0;
        in_valid  = 1'b0;
        in_word   = '0;
        read      = '0;
        hold_read = 1'b0;
        repeat (5) @(posedge clk);
        reset_b <= 1'b1;
        @(posedge clk);
        send_random_packets(150);
        hold_read = 1'b1;                          // back pressure until the FIFOs fill
        fork
            send_random_packets(30);
            begin
                repeat (hold_cycles) @(posedge clk);
                hold_read = 1'b0;
            end
        join
        if (held_suspend_cycles == 0) begin
            flag_protocol_error("suspend never rose while the outputs were held");
        end
        repeat (20) send_packet(router_pkg::max_packet_words, 0, 1'b0);
        in_valid <= 1'b0;
        while (words_owed() != 0) @(posedge clk);
        repeat (10) @(posedge clk);
        for (int k = 0; k < router_pkg::num_ports; k++) begin
            check_count(k, rx_count[k], exp_count[k]);
        end
        $display("errors: beat %0d, count %0d, protocol %0d, assertion %0d",
                 beat_errors, count_errors, protocol_errors, assertion_failures());
        if (beat_errors + count_errors + protocol_errors + assertion_failures() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
